// ==== sim.f ====
source/uart_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_regs.sv
source/echo_ctrl.sv
source/uart_echo_top.sv
bench/tb_uart_echo.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the uart echo testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_uart_echo -f sim.f -o tb_uart_echo_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_uart_echo_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

// ==== bench/tb_uart_echo.sv ====
// tb_uart_echo testbench with clock, reset, serial driver and monitor, directed tests and watchdog
`default_nettype none

module tb_uart_echo;
    import uart_pkg::*;

    localparam int BIT_CYCLES      = int'(BAUD_DIV);
    localparam int FRAME_CYCLES    = 10 * BIT_CYCLES;
    localparam int ECHO_WAIT       = FRAME_CYCLES + 2 * int'(ECHO_GAP) + 100;
    localparam int GLITCH_WINDOW   = 2 * (FRAME_CYCLES + 2 * int'(ECHO_GAP));
    localparam int BYTE_COUNT      = 11;   // bytes sent over all tests
    localparam int WATCHDOG_CYCLES = 8 * BYTE_COUNT * ECHO_WAIT;

    logic   pll_clk;
    logic   rst_n;
    logic   i_rx;
    logic   o_tx;
    logic   o_led;
    string  cur_test;
    int     test_errors;
    int     pass_count;
    int     fail_count;
    integer seed;

    uart_echo_top uart_echo_top_inst (
        .pll_clk (pll_clk),
        .rst_n   (rst_n),
        .i_rx    (i_rx),
        .o_tx    (o_tx),
        .o_led   (o_led)
    );

    always #4 pll_clk = ~pll_clk;

    // all stimulus and sampling happens just after the rising edge
    task automatic tick();
        @(posedge pll_clk);
        #1;
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("%s: PASS", cur_test);
            pass_count++;
        end else begin
            $display("%s: FAIL with %0d errors", cur_test, test_errors);
            fail_count++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR %s: %s", cur_test, what);
        test_errors++;
    endtask

    task automatic check_byte(input string what, input uart_byte_t exp, input uart_byte_t act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %02h, got %02h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %b, got %b", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic send_byte(input uart_byte_t data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};             // stop, data, start
        for (int k = 0; k < 10; k++) begin
            i_rx = frame[k];
            repeat (BIT_CYCLES) tick();
        end
    endtask

    // returns at the last cycle of the stop bit
    task automatic recv_byte(input int max_wait, output uart_byte_t data, output logic ok);
        logic [9:0] frame;
        logic       steady;
        int         waited;
        data   = '0;
        ok     = 1'b0;
        steady = 1'b1;
        waited = 0;
        while (o_tx !== 1'b0 && waited < max_wait) begin
            tick();
            waited++;
        end
        if (o_tx !== 1'b0) begin
            report_error("no start bit appeared on o_tx in time");
            return;
        end
        for (int k = 0; k < 10; k++) begin
            for (int j = 0; j < BIT_CYCLES; j++) begin
                if (k != 0 || j != 0) begin
                    tick();
                end
                if (j == 0) begin
                    frame[k] = o_tx;
                end else if (o_tx !== frame[k]) begin
                    steady = 1'b0;              // edge inside a bit period
                end
            end
        end
        if (!steady) begin
            report_error("o_tx changed inside a bit period, frame timing is wrong");
        end
        if (frame[9] !== 1'b1) begin
            report_error("stop bit on o_tx was low");
        end
        ok   = steady && frame[9] === 1'b1;
        data = frame[8:1];
    endtask

    task automatic idle_after_reset();
        begin_test("idle_after_reset");
        for (int i = 0; i < 50 && test_errors == 0; i++) begin
            check_bit("o_tx idle", 1'b1, o_tx);
            check_bit("o_led off", 1'b1, o_led);
            tick();
        end
        end_test();
    endtask

    task automatic echo_single_byte();
        uart_byte_t got;
        logic       ok;
        begin_test("echo_single_byte");
        send_byte(8'hA5);
        recv_byte(ECHO_WAIT, got, ok);
        if (ok) begin
            check_byte("echo", 8'hA5, got);
        end
        end_test();
    endtask

    task automatic led_follows_irq();
        uart_byte_t got;
        logic       ok;
        int         waited;
        begin_test("led_follows_irq");
        send_byte(8'h3C);
        check_bit("led after rx stop bit", 1'b0, o_led);   // rx pending and enabled
        check_bit("tx idle before echo", 1'b1, o_tx);
        recv_byte(ECHO_WAIT, got, ok);
        if (ok) begin
            check_byte("echo", 8'h3C, got);
        end
        waited = 0;
        while (o_led !== 1'b1 && waited < 20) begin
            tick();
            waited++;
        end
        check_bit("led after clear", 1'b1, o_led);
        end_test();
    endtask

    task automatic echo_random_bytes();
        logic [31:0] rnd;
        uart_byte_t  sent;
        uart_byte_t  got;
        logic        ok;
        begin_test("echo_random_bytes");
        for (int i = 0; i < 8; i++) begin
            rnd  = $random(seed);
            sent = rnd[7:0];
            send_byte(sent);
            recv_byte(ECHO_WAIT, got, ok);
            if (ok) begin
                check_byte($sformatf("byte %0d", i), sent, got);
            end
        end
        end_test();
    endtask

    task automatic reject_glitch();
        uart_byte_t got;
        logic       ok;
        logic       quiet;
        begin_test("reject_glitch");
        i_rx = 1'b0;
        repeat (BIT_CYCLES / 4) tick();         // quarter-bit low pulse
        i_rx  = 1'b1;
        quiet = 1'b1;
        repeat (GLITCH_WINDOW) begin
            tick();
            if (o_tx !== 1'b1) begin
                quiet = 1'b0;
            end
        end
        check_bit("o_tx quiet after glitch", 1'b1, quiet);
        send_byte(8'h5A);
        recv_byte(ECHO_WAIT, got, ok);
        if (ok) begin
            check_byte("echo after glitch", 8'h5A, got);
        end
        end_test();
    endtask

    initial begin
        pll_clk     = 1'b0;
        rst_n       = 1'b0;
        i_rx        = 1'b1;                     // line idles high
        seed        = 32'h2bd5;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        cur_test    = "reset";
        repeat (10) tick();
        rst_n = 1'b1;
        idle_after_reset();
        echo_single_byte();
        led_follows_irq();
        echo_random_bytes();
        reject_glitch();
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge pll_clk);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/uart_echo_top.sv ====
// uart_echo_top joining echo controller, register block, rx and tx engines and the led
`default_nettype none

module uart_echo_top (
    input  wire logic pll_clk,
    input  wire logic rst_n,
    input  wire logic i_rx,
    output logic      o_tx,
    output logic      o_led
);
    import uart_pkg::*;

    bus_req_t   bus_req;
    bus_rsp_t   bus_rsp;
    uart_byte_t rx_byte;
    logic       rx_valid;
    uart_byte_t tx_byte;
    logic       tx_start;
    logic       tx_busy;
    baud_div_t  baud_div;
    logic       irq;

    echo_ctrl echo_ctrl_inst (
        .pll_clk (pll_clk),
        .rst_n   (rst_n),
        .i_rsp   (bus_rsp),
        .o_req   (bus_req)
    );

    uart_regs uart_regs_inst (
        .pll_clk    (pll_clk),
        .rst_n      (rst_n),
        .i_req      (bus_req),
        .o_rsp      (bus_rsp),
        .i_rx_byte  (rx_byte),
        .i_rx_valid (rx_valid),
        .i_tx_busy  (tx_busy),
        .o_tx_start (tx_start),
        .o_tx_byte  (tx_byte),
        .o_baud_div (baud_div),
        .o_irq      (irq)
    );

    uart_rx uart_rx_inst (
        .pll_clk    (pll_clk),
        .rst_n      (rst_n),
        .i_rx       (i_rx),
        .i_baud_div (baud_div),
        .o_rx_byte  (rx_byte),
        .o_rx_valid (rx_valid)
    );

    uart_tx uart_tx_inst (
        .pll_clk    (pll_clk),
        .rst_n      (rst_n),
        .i_baud_div (baud_div),
        .i_tx_start (tx_start),
        .i_tx_byte  (tx_byte),
        .o_tx       (o_tx),
        .o_tx_busy  (tx_busy)
    );

    assign o_led = ~irq;    // active-low led, on while an irq is pending

endmodule

`default_nettype wire

// ==== source/echo_ctrl.sv ====
// echo_ctrl bus master FSM for uart init, status polling, echo and interrupt clear
`default_nettype none

module echo_ctrl (
    input  wire logic               pll_clk,
    input  wire logic               rst_n,
    input  wire uart_pkg::bus_rsp_t i_rsp,
    output uart_pkg::bus_req_t      o_req
);
    import uart_pkg::*;

    typedef enum logic [3:0] {
        WAIT, WAIT_DELAY, INIT, WRITE_BAUD_H, WRITE_INT_EN, READ_STATUS, COMP_STATUS,
        START_ECHO, WAIT_BEFORE_ECHO, WRITE_ECHO, POLL_TX, CHECK_TX, CLEAR_INT
    } state_t;

    state_t     state;
    state_t     tag;                        // where to go once the wait ends
    logic [7:0] gap_cnt;
    uart_byte_t rd_latch;                   // low byte of the last read

    function automatic bus_req_t make_req(logic wr, bus_addr_t addr, bus_word_t wdata);
        return '{en: 1'b1, wr: wr, addr: addr, wdata: wdata};
    endfunction

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            o_req   <= '0;
            state   <= INIT;
            tag     <= INIT;
            gap_cnt <= '0;
        end else begin
            case (state)
                WAIT: begin
                    if (i_rsp.ready) begin
                        o_req.en <= 1'b0;
                        o_req.wr <= 1'b0;
                        state    <= tag;
                    end
                end
                WAIT_DELAY: begin
                    if (gap_cnt == '0) begin
                        state <= tag;
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                INIT: begin
                    o_req <= make_req(1'b1, UART_BAUD_L_ADDR, 32'(BAUD_DIV[7:0]));
                    tag   <= WRITE_BAUD_H;
                    state <= WAIT;
                end
                WRITE_BAUD_H: begin
                    o_req <= make_req(1'b1, UART_BAUD_H_ADDR, 32'(BAUD_DIV[15:8]));
                    tag   <= WRITE_INT_EN;
                    state <= WAIT;
                end
                WRITE_INT_EN: begin
                    o_req <= make_req(1'b1, UART_INT_ADDR, 32'b11); // rx and tx irqs
                    tag   <= READ_STATUS;
                    state <= WAIT;
                end
                READ_STATUS: begin
                    o_req <= make_req(1'b0, UART_STATUS_ADDR, '0);
                    tag   <= COMP_STATUS;
                    state <= WAIT;
                end
                COMP_STATUS: begin
                    if (rd_latch[STAT_RX_READY_BIT] && !rd_latch[STAT_TX_FULL_BIT]) begin
                        gap_cnt <= 8'(ECHO_GAP - 1);
                        tag     <= START_ECHO;
                        state   <= WAIT_DELAY;
                    end else begin
                        o_req <= make_req(1'b0, UART_STATUS_ADDR, '0); // poll again
                        tag   <= COMP_STATUS;
                        state <= WAIT;
                    end
                end
                START_ECHO: begin
                    o_req <= make_req(1'b0, UART_DATA_ADDR, '0);
                    tag   <= WAIT_BEFORE_ECHO;
                    state <= WAIT;
                end
                WAIT_BEFORE_ECHO: begin
                    gap_cnt <= 8'(ECHO_GAP - 1);    // keeps the led lit a while
                    tag     <= WRITE_ECHO;
                    state   <= WAIT_DELAY;
                end
                WRITE_ECHO: begin
                    o_req <= make_req(1'b1, UART_DATA_ADDR, 32'(rd_latch));
                    tag   <= POLL_TX;
                    state <= WAIT;
                end
                POLL_TX: begin
                    o_req <= make_req(1'b0, UART_STATUS_ADDR, '0);
                    tag   <= CHECK_TX;
                    state <= WAIT;
                end
                CHECK_TX: begin
                    if (rd_latch[STAT_TX_FULL_BIT]) begin
                        o_req <= make_req(1'b0, UART_STATUS_ADDR, '0); // echo still on the line
                        tag   <= CHECK_TX;
                        state <= WAIT;
                    end else begin
                        state <= CLEAR_INT;
                    end
                end
                CLEAR_INT: begin
                    o_req <= make_req(1'b1, UART_INT_PENDING_ADDR, 32'b11);
                    tag   <= READ_STATUS;
                    state <= WAIT;
                end
                default: state <= READ_STATUS;
            endcase
        end
    end

    always_ff @(posedge pll_clk) begin
        if (i_rsp.ready && !o_req.wr) begin
            rd_latch <= i_rsp.rdata[7:0];
        end
    end

    // the controller only ever addresses mapped registers
    no_bus_err: assert property (
        @(posedge pll_clk) disable iff (!rst_n) i_rsp.ready |-> !i_rsp.err
    );

endmodule

`default_nettype wire

// ==== source/uart_regs.sv ====
// uart_regs bus register block joining rx and tx with baud, enable and pending registers
`default_nettype none

module uart_regs (
    input  wire logic                 pll_clk,
    input  wire logic                 rst_n,
    input  wire uart_pkg::bus_req_t   i_req,
    output uart_pkg::bus_rsp_t        o_rsp,
    input  wire uart_pkg::uart_byte_t i_rx_byte,
    input  wire logic                 i_rx_valid,
    input  wire logic                 i_tx_busy,
    output logic                      o_tx_start,
    output uart_pkg::uart_byte_t      o_tx_byte,
    output uart_pkg::baud_div_t       o_baud_div,
    output logic                      o_irq
);
    import uart_pkg::*;

    logic       rsp_ready;
    logic       rsp_err;
    bus_word_t  rsp_rdata;
    logic       access;                     // first cycle of an open request
    logic       wr_access;
    logic       mapped;
    bus_word_t  rd_word;
    uart_byte_t rx_hold;
    logic       rx_ready;
    uart_byte_t baud_l;
    uart_byte_t baud_h;
    logic [1:0] int_en;
    logic [1:0] int_pend;
    logic [1:0] pend_set;
    logic [1:0] pend_clr;
    logic       tx_busy_q;

    assign access     = i_req.en && !rsp_ready;
    assign wr_access  = access && i_req.wr;
    assign o_rsp      = '{ready: rsp_ready, err: rsp_err, rdata: rsp_rdata};
    assign o_baud_div = {baud_h, baud_l};
    assign o_irq      = |(int_pend & int_en);

    always_comb begin
        pend_set             = '0;
        pend_set[INT_RX_BIT] = i_rx_valid;
        pend_set[INT_TX_BIT] = tx_busy_q && !i_tx_busy;    // end of transmission
        pend_clr = '0;
        if (wr_access && i_req.addr == UART_INT_PENDING_ADDR) begin
            pend_clr = i_req.wdata[1:0];                    // write 1 to clear
        end
    end

    always_comb begin
        mapped  = 1'b1;
        rd_word = '0;
        case (i_req.addr)
            UART_DATA_ADDR:        rd_word[7:0] = rx_hold;
            UART_STATUS_ADDR: begin
                rd_word[STAT_RX_READY_BIT] = rx_ready;
                rd_word[STAT_TX_FULL_BIT]  = i_tx_busy;     // no fifo, busy means full
            end
            UART_INT_ADDR:         rd_word[1:0] = int_en;
            UART_INT_PENDING_ADDR: rd_word[1:0] = int_pend;
            UART_BAUD_L_ADDR:      rd_word[7:0] = baud_l;
            UART_BAUD_H_ADDR:      rd_word[7:0] = baud_h;
            default:               mapped = 1'b0;
        endcase
    end

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            rsp_ready  <= 1'b0;
            rsp_err    <= 1'b0;
            o_tx_start <= 1'b0;
            tx_busy_q  <= 1'b0;
            rx_ready   <= 1'b0;
            int_en     <= '0;
            int_pend   <= '0;
            baud_l     <= '0;
            baud_h     <= '0;
        end else begin
            rsp_ready  <= access;
            rsp_err    <= access && !mapped;
            o_tx_start <= wr_access && i_req.addr == UART_DATA_ADDR;
            tx_busy_q  <= i_tx_busy;
            int_pend   <= (int_pend & ~pend_clr) | pend_set;
            if (access && !i_req.wr && i_req.addr == UART_DATA_ADDR) begin
                rx_ready <= 1'b0;
            end
            if (i_rx_valid) begin
                rx_ready <= 1'b1;                           // new byte wins over a read
            end
            if (wr_access) begin
                case (i_req.addr)
                    UART_INT_ADDR:    int_en <= i_req.wdata[1:0];
                    UART_BAUD_L_ADDR: baud_l <= i_req.wdata[7:0];
                    UART_BAUD_H_ADDR: baud_h <= i_req.wdata[7:0];
                    default:          ;
                endcase
            end
        end
    end

    always_ff @(posedge pll_clk) begin
        if (i_rx_valid) begin
            rx_hold <= i_rx_byte;                           // overwrites an unread byte
        end
        if (wr_access && i_req.addr == UART_DATA_ADDR) begin
            o_tx_byte <= i_req.wdata[7:0];
        end
        if (access) begin
            rsp_rdata <= rd_word;
        end
    end

    // master keeps the request steady into the acknowledge cycle
    req_held_until_ready: assert property (
        @(posedge pll_clk) disable iff (!rst_n)
            i_req.en && !rsp_ready |=> i_req.en && $stable(i_req)
    );

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
// uart_tx 8n1 serial transmitter sending one framed byte at a time
`default_nettype none

module uart_tx (
    input  wire logic                 pll_clk,
    input  wire logic                 rst_n,
    input  wire uart_pkg::baud_div_t  i_baud_div,
    input  wire logic                 i_tx_start,
    input  wire uart_pkg::uart_byte_t i_tx_byte,
    output logic                      o_tx,
    output logic                      o_tx_busy
);
    import uart_pkg::*;

    logic [9:0] frame;                      // stop, data, start, shifted out from bit 0
    baud_div_t  cnt;
    logic [3:0] bit_idx;

    assign o_tx = frame[0];

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            frame     <= '1;                // line idles high
            o_tx_busy <= 1'b0;
            cnt       <= '0;
            bit_idx   <= '0;
        end else if (!o_tx_busy) begin
            cnt     <= '0;
            bit_idx <= '0;
            if (i_tx_start && i_baud_div != '0) begin
                frame     <= {1'b1, i_tx_byte, 1'b0};
                o_tx_busy <= 1'b1;
            end
        end else if (cnt == i_baud_div - 1'b1) begin
            cnt     <= '0;
            frame   <= {1'b1, frame[9:1]};  // refill with idle level
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 4'd9) begin
                o_tx_busy <= 1'b0;          // stop bit done
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // after ten shifts the frame must have drained back to all ones
    tx_idle_high: assert property (
        @(posedge pll_clk) disable iff (!rst_n) !o_tx_busy |-> o_tx
    );

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
// uart_rx 8n1 serial receiver with mid-bit start check and lsb-first sampling
`default_nettype none

module uart_rx (
    input  wire logic                pll_clk,
    input  wire logic                rst_n,
    input  wire logic                i_rx,
    input  wire uart_pkg::baud_div_t i_baud_div,
    output uart_pkg::uart_byte_t     o_rx_byte,
    output logic                     o_rx_valid
);
    import uart_pkg::*;

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t     state;
    logic [1:0] rx_sync;                // two-flop synchroniser
    logic       rx_s;
    baud_div_t  cnt;
    baud_div_t  half_bit;
    logic       bit_end;                // last cycle of a full bit period
    logic [2:0] bit_idx;
    uart_byte_t shreg;

    assign rx_s     = rx_sync[1];
    assign half_bit = i_baud_div >> 1;
    assign bit_end  = (cnt == i_baud_div - 1'b1);

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            rx_sync    <= 2'b11;
            state      <= IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[0], i_rx};
            o_rx_valid <= 1'b0;
            case (state)
                IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx_s && i_baud_div != '0) begin
                        state <= START;             // line dropped, maybe a start bit
                    end
                end
                START: begin
                    if (cnt == half_bit - 1'b1) begin
                        cnt   <= '0;
                        state <= rx_s ? IDLE : DATA; // high again at mid-bit is a glitch
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        o_rx_valid <= rx_s;         // low stop bit drops the byte
                        state      <= IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge pll_clk) begin
        if (state == DATA && bit_end) begin
            shreg <= {rx_s, shreg[7:1]};            // lsb arrives first
        end
        if (state == STOP && bit_end) begin
            o_rx_byte <= shreg;
        end
    end

endmodule

`default_nettype wire

// ==== source/uart_pkg.sv ====
// uart_pkg with register map, bus structs, vector typedefs and timing localparams
`default_nettype none

package uart_pkg;

    typedef logic [7:0]  uart_byte_t;   // one serial data byte
    typedef logic [15:0] baud_div_t;    // bit period in pll_clk cycles
    typedef logic [7:0]  bus_addr_t;    // register address
    typedef logic [31:0] bus_word_t;    // bus data word

    typedef struct packed {
        logic      en;                  // held until ready
        logic      wr;
        bus_addr_t addr;
        bus_word_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic      ready;               // one-cycle acknowledge
        logic      err;                 // unmapped address
        bus_word_t rdata;
    } bus_rsp_t;

    // register map
    localparam bus_addr_t UART_DATA_ADDR        = 8'h00;
    localparam bus_addr_t UART_STATUS_ADDR      = 8'h04;
    localparam bus_addr_t UART_INT_ADDR         = 8'h08;
    localparam bus_addr_t UART_INT_PENDING_ADDR = 8'h0C;
    localparam bus_addr_t UART_BAUD_L_ADDR      = 8'h10;
    localparam bus_addr_t UART_BAUD_H_ADDR      = 8'h14;

    localparam int STAT_RX_READY_BIT = 0;
    localparam int STAT_TX_FULL_BIT  = 1;   // tx engine busy

    localparam int INT_RX_BIT = 0;
    localparam int INT_TX_BIT = 1;

    // sized for simulation (hardware runs 469 per bit and a gap near 843750)
    localparam baud_div_t   BAUD_DIV = 16'd16;
    localparam int unsigned ECHO_GAP = 64;

endpackage

`default_nettype wire
